// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= trap_unit.f
RTL_TOP   ?= trap_unit
TB_TOP    ?= tb_trap_unit
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	@out="$$(./$(BUILD_DIR)/$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== hw/irq_arbiter.sv ====
// synchronises the external interrupt lines into mip and selects the interrupt to take.
`timescale 1ns/1ps
`default_nettype none

module irq_arbiter
    import trap_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  wire logic      clk,
    input  wire logic      rstn,
    input  wire logic      ext_msip,
    input  wire logic      ext_mtip,
    input  wire logic      ext_meip,
    input  wire xlen_t     mie_bits,
    input  wire logic      mstatus_mie,
    input  wire priv_e     prv,
    output xlen_t          mip_bits,
    output logic           irq_req,
    output irq_code_t      irq_code
);

    // one flop chain per line, packed as {meip, mtip, msip}.
    logic [2:0] sync_q [SYNC_STAGES];

    xlen_t pending;
    logic  irq_allowed;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= 3'b000;
            end
        end else begin
            sync_q[0] <= {ext_meip, ext_mtip, ext_msip};
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // place the synchronised lines at their mip positions.
    always_comb begin
        mip_bits           = '0;
        mip_bits[IRQ_MSIP] = sync_q[SYNC_STAGES-1][0];
        mip_bits[IRQ_MTIP] = sync_q[SYNC_STAGES-1][1];
        mip_bits[IRQ_MEIP] = sync_q[SYNC_STAGES-1][2];
    end

    assign pending = mip_bits & mie_bits;

    // user mode always takes machine interrupts, machine mode only with MIE.
    assign irq_allowed = (prv == PRV_U) || mstatus_mie;

    // fixed priority: external, then software, then timer.
    always_comb begin
        irq_req  = 1'b0;
        irq_code = '0;
        if (pending[IRQ_MEIP]) begin
            irq_req  = irq_allowed;
            irq_code = IRQ_MEIP;
        end else if (pending[IRQ_MSIP]) begin
            irq_req  = irq_allowed;
            irq_code = IRQ_MSIP;
        end else if (pending[IRQ_MTIP]) begin
            irq_req  = irq_allowed;
            irq_code = IRQ_MTIP;
        end
    end

endmodule

`default_nettype wire

// ==== hw/priv_fsm.sv ====
// privilege state machine and mstatus fields; picks the one event the unit acts on each cycle.
`timescale 1ns/1ps
`default_nettype none

module priv_fsm
    import trap_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rstn,
    input  wire logic      trap_en,
    input  wire logic      mret,
    input  wire logic      irq_req,
    input  wire logic      csr_wr,
    input  wire csr_addr_t csr_waddr,
    input  wire xlen_t     csr_wdata,
    output trap_event_e    trap_event,
    output priv_e          prv,
    output logic           mstatus_mie,
    output xlen_t          mstatus_word,
    output logic           irq_trigger,
    output logic           eret_en
);

    logic  mpie_q;
    priv_e mpp_q;
    priv_e mpp_wr;
    logic  mstatus_we;

    // trap beats interrupt, interrupt beats mret, mret beats a CSR write.
    always_comb begin
        if (trap_en) begin
            trap_event = EV_TRAP;
        end else if (irq_req) begin
            trap_event = EV_IRQ;
        end else if (mret) begin
            trap_event = EV_MRET;
        end else begin
            trap_event = EV_NONE;
        end
    end

    assign irq_trigger = (trap_event == EV_IRQ);
    assign eret_en     = (trap_event == EV_MRET);

    assign mstatus_we = (trap_event == EV_NONE) && csr_wr && (csr_waddr == CSR_MSTATUS);

    // MPP holds only legal modes; anything but machine reads back as user.
    assign mpp_wr = (csr_wdata[MSTATUS_MPP_LSB +: 2] == PRV_M) ? PRV_M : PRV_U;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prv         <= PRV_M;
            mstatus_mie <= 1'b0;
            mpie_q      <= 1'b0;
            mpp_q       <= PRV_U;
        end else begin
            case (trap_event)
                EV_TRAP, EV_IRQ: begin
                    mpp_q       <= prv;
                    mpie_q      <= mstatus_mie;
                    mstatus_mie <= 1'b0;
                    prv         <= PRV_M;
                end
                EV_MRET: begin
                    prv         <= mpp_q;
                    mstatus_mie <= mpie_q;
                    mpie_q      <= 1'b1;
                    mpp_q       <= PRV_U;
                end
                default: begin
                    if (mstatus_we) begin
                        mstatus_mie <= csr_wdata[MSTATUS_MIE_BIT];
                        mpie_q      <= csr_wdata[MSTATUS_MPIE_BIT];
                        mpp_q       <= mpp_wr;
                    end
                end
            endcase
        end
    end

    // compose the readable mstatus; other fields are hardwired to zero.
    always_comb begin
        mstatus_word                            = '0;
        mstatus_word[MSTATUS_MIE_BIT]           = mstatus_mie;
        mstatus_word[MSTATUS_MPIE_BIT]          = mpie_q;
        mstatus_word[MSTATUS_MPP_LSB +: 2]      = mpp_q;
    end

endmodule

`default_nettype wire

// ==== hw/trap_csr_file.sv ====
// machine trap CSRs with write decode, read mux, and the trap vector and cause outputs.
`timescale 1ns/1ps
`default_nettype none

module trap_csr_file
    import trap_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire trap_event_e trap_event,
    input  wire irq_code_t   irq_code,
    input  wire xlen_t       trap_epc,
    input  wire xlen_t       trap_cause,
    input  wire xlen_t       trap_val,
    input  wire xlen_t       mip_bits,
    input  wire xlen_t       mstatus_word,
    input  wire logic        csr_wr,
    input  wire csr_addr_t   csr_waddr,
    input  wire csr_addr_t   csr_raddr,
    input  wire xlen_t       csr_wdata,
    output xlen_t            mie_bits,
    output xlen_t            csr_rdata,
    output xlen_t            trap_vec,
    output xlen_t            ret_epc,
    output xlen_t            cause,
    output xlen_t            tval
);

    // writable enable bits in mie.
    localparam xlen_t MIE_MASK = (xlen_t'(1) << IRQ_MSIP) |
                                 (xlen_t'(1) << IRQ_MTIP) |
                                 (xlen_t'(1) << IRQ_MEIP);

    xlen_t mtvec_q;
    xlen_t mscratch_q;
    xlen_t mepc_q;
    xlen_t mcause_q;
    xlen_t mtval_q;
    xlen_t mie_q;

    xlen_t irq_cause;
    xlen_t vec_base;
    logic  csr_we;

    // writes only land in cycles with no trap, interrupt or mret.
    assign csr_we = csr_wr && (trap_event == EV_NONE);

    // interrupt flag plus the code of the winning line.
    always_comb begin
        irq_cause                = '0;
        irq_cause[CAUSE_INT_BIT] = 1'b1;
        irq_cause[3:0]           = irq_code;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mie_q      <= '0;
        end else if (csr_we) begin
            case (csr_waddr)
                CSR_MTVEC:    mtvec_q    <= csr_wdata & ~xlen_t'(32'h2);
                CSR_MSCRATCH: mscratch_q <= csr_wdata;
                CSR_MIE:      mie_q      <= csr_wdata & MIE_MASK;
                default:      ;
            endcase
        end
    end

    // trap state, updated by trap entry or by software.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end else begin
            case (trap_event)
                EV_TRAP: begin
                    mepc_q   <= trap_epc & ~xlen_t'(32'h1);
                    mcause_q <= trap_cause;
                    mtval_q  <= trap_val;
                end
                EV_IRQ: begin
                    mepc_q   <= trap_epc & ~xlen_t'(32'h1);
                    mcause_q <= irq_cause;
                    mtval_q  <= '0;
                end
                EV_NONE: begin
                    if (csr_wr) begin
                        case (csr_waddr)
                            CSR_MEPC:   mepc_q   <= csr_wdata & ~xlen_t'(32'h1);
                            CSR_MCAUSE: mcause_q <= csr_wdata;
                            CSR_MTVAL:  mtval_q  <= csr_wdata;
                            default:    ;
                        endcase
                    end
                end
                default: ;
            endcase
        end
    end

    assign mie_bits = mie_q;
    assign ret_epc  = mepc_q;

    // vectored mode offsets interrupts only; synchronous traps use the base.
    assign vec_base = mtvec_q & ~xlen_t'(32'h3);

    always_comb begin
        trap_vec = vec_base;
        if (trap_event == EV_IRQ && mtvec_q[0]) begin
            trap_vec = vec_base + {26'd0, irq_code, 2'b00};
        end
    end

    always_comb begin
        case (trap_event)
            EV_TRAP: cause = trap_cause;
            EV_IRQ:  cause = irq_cause;
            default: cause = '0;
        endcase
    end

    assign tval = (trap_event == EV_TRAP) ? trap_val : '0;

    // unimplemented addresses read as zero.
    always_comb begin
        case (csr_raddr)
            CSR_MSTATUS:  csr_rdata = mstatus_word;
            CSR_MIE:      csr_rdata = mie_q;
            CSR_MTVEC:    csr_rdata = mtvec_q;
            CSR_MSCRATCH: csr_rdata = mscratch_q;
            CSR_MEPC:     csr_rdata = mepc_q;
            CSR_MCAUSE:   csr_rdata = mcause_q;
            CSR_MTVAL:    csr_rdata = mtval_q;
            CSR_MIP:      csr_rdata = mip_bits;
            default:      csr_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/trap_pkg.sv ====
// shared types, CSR addresses, field positions and interrupt codes; imported by every trap unit module.
`default_nettype none

package trap_pkg;

    // data word and address width of the core.
    typedef logic [31:0] xlen_t;

    // CSR address as carried on the CSR port.
    typedef logic [11:0] csr_addr_t;

    // exception code of an interrupt.
    typedef logic [3:0] irq_code_t;

    // only machine and user mode exist, at their architectural encodings.
    typedef enum logic [1:0] {
        PRV_U = 2'b00,
        PRV_M = 2'b11
    } priv_e;

    // the single event the unit acts on in a cycle.
    typedef enum logic [1:0] {
        EV_NONE = 2'd0,
        EV_TRAP = 2'd1,
        EV_IRQ  = 2'd2,
        EV_MRET = 2'd3
    } trap_event_e;

    // machine trap setup.
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;

    // machine trap handling.
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_MIP      = 12'h344;

    // mstatus fields kept by this unit.
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    // interrupt codes, which double as bit positions in mie and mip.
    localparam irq_code_t IRQ_MSIP = 4'd3;
    localparam irq_code_t IRQ_MTIP = 4'd7;
    localparam irq_code_t IRQ_MEIP = 4'd11;

    // interrupt flag in mcause.
    localparam int CAUSE_INT_BIT = 31;

endpackage

`default_nettype wire

// ==== hw/trap_unit.sv ====
// top level of the machine-mode trap and interrupt unit; connects the arbiter, FSM and CSR file.
`timescale 1ns/1ps
`default_nettype none

module trap_unit
    import trap_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  wire logic      clk,
    input  wire logic      rstn,

    // CSR port.
    input  wire logic      csr_wr,
    input  wire csr_addr_t csr_waddr,
    input  wire csr_addr_t csr_raddr,
    input  wire xlen_t     csr_wdata,
    output xlen_t          csr_rdata,

    // trap request from the core.
    input  wire logic      trap_en,
    input  wire xlen_t     trap_epc,
    input  wire xlen_t     trap_cause,
    input  wire xlen_t     trap_val,
    input  wire logic      mret,

    // external interrupt lines.
    input  wire logic      ext_msip,
    input  wire logic      ext_mtip,
    input  wire logic      ext_meip,

    output priv_e          prv,
    output logic           irq_trigger,
    output logic           eret_en,
    output xlen_t          trap_vec,
    output xlen_t          ret_epc,
    output xlen_t          cause,
    output xlen_t          tval
);

    logic        irq_req;
    irq_code_t   irq_code;
    xlen_t       mip_bits;
    xlen_t       mie_bits;
    trap_event_e trap_event;
    logic        mstatus_mie;
    xlen_t       mstatus_word;

    irq_arbiter #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_irq_arbiter (
        .clk         (clk),
        .rstn        (rstn),
        .ext_msip    (ext_msip),
        .ext_mtip    (ext_mtip),
        .ext_meip    (ext_meip),
        .mie_bits    (mie_bits),
        .mstatus_mie (mstatus_mie),
        .prv         (prv),
        .mip_bits    (mip_bits),
        .irq_req     (irq_req),
        .irq_code    (irq_code)
    );

    priv_fsm u_priv_fsm (
        .clk          (clk),
        .rstn         (rstn),
        .trap_en      (trap_en),
        .mret         (mret),
        .irq_req      (irq_req),
        .csr_wr       (csr_wr),
        .csr_waddr    (csr_waddr),
        .csr_wdata    (csr_wdata),
        .trap_event   (trap_event),
        .prv          (prv),
        .mstatus_mie  (mstatus_mie),
        .mstatus_word (mstatus_word),
        .irq_trigger  (irq_trigger),
        .eret_en      (eret_en)
    );

    trap_csr_file u_trap_csr_file (
        .clk          (clk),
        .rstn         (rstn),
        .trap_event   (trap_event),
        .irq_code     (irq_code),
        .trap_epc     (trap_epc),
        .trap_cause   (trap_cause),
        .trap_val     (trap_val),
        .mip_bits     (mip_bits),
        .mstatus_word (mstatus_word),
        .csr_wr       (csr_wr),
        .csr_waddr    (csr_waddr),
        .csr_raddr    (csr_raddr),
        .csr_wdata    (csr_wdata),
        .mie_bits     (mie_bits),
        .csr_rdata    (csr_rdata),
        .trap_vec     (trap_vec),
        .ret_epc      (ret_epc),
        .cause        (cause),
        .tval         (tval)
    );

endmodule

`default_nettype wire

// ==== sim/tb_trap_unit_checks.svh ====
// compare tasks, error counters and random data source for the trap unit testbench; included in its module.
`ifndef TB_TRAP_UNIT_CHECKS_SVH
`define TB_TRAP_UNIT_CHECKS_SVH

int    mismatch_count    = 0;
int    other_error_count = 0;
xlen_t lcg_state         = 32'd82;

// 32-bit linear congruential generator.
function automatic xlen_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

task automatic check_xlen(input string name, input xlen_t got, input xlen_t want);
    if (got !== want) begin
        mismatch_count++;
        $display("MISMATCH at %0t: %s received %h expected %h", $time, name, got, want);
    end
endtask

task automatic check_priv(input string name, input priv_e got, input priv_e want);
    if (got !== want) begin
        mismatch_count++;
        $display("MISMATCH at %0t: %s received %b expected %b", $time, name, got, want);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
        mismatch_count++;
        $display("MISMATCH at %0t: %s received %b expected %b", $time, name, got, want);
    end
endtask

// reports a failure that is not a value compare.
task automatic report_error(input string what);
    other_error_count++;
    $display("ERROR at %0t: %s", $time, what);
endtask

`endif

// ==== sim/tb_trap_unit.sv ====
// testbench for the trap unit; applies a table of CSR, trap, mret and interrupt steps and checks each.
`timescale 1ns/1ps
`default_nettype none

module tb_trap_unit
    import trap_pkg::*;
();

    localparam int SYNC_STAGES  = 2;
    localparam int RESET_CYCLES = 10;

    // row kinds.
    localparam int OP_WR    = 0;
    localparam int OP_RD    = 1;
    localparam int OP_TRAP  = 2;
    localparam int OP_MRET  = 3;
    localparam int OP_LINES = 4;
    localparam int OP_WAIT  = 5;

    logic      clk;
    logic      rstn;
    logic      csr_wr;
    csr_addr_t csr_waddr;
    csr_addr_t csr_raddr;
    xlen_t     csr_wdata;
    xlen_t     csr_rdata;
    logic      trap_en;
    xlen_t     trap_epc;
    xlen_t     trap_cause;
    xlen_t     trap_val;
    logic      mret;
    logic      ext_msip;
    logic      ext_mtip;
    logic      ext_meip;
    priv_e     prv;
    logic      irq_trigger;
    logic      eret_en;
    xlen_t     trap_vec;
    xlen_t     ret_epc;
    xlen_t     cause;
    xlen_t     tval;

    // a is write data, epc or the lines {meip, mtip, msip}; b is a cause; c is tval or latency.
    typedef struct {
        int        op;
        csr_addr_t addr;
        xlen_t     a;
        xlen_t     b;
        xlen_t     c;
        xlen_t     exp_val;
        priv_e     exp_prv;
        logic      exp_irq;
        logic      exp_eret;
    } row_t;

    row_t rows[$];
    int   cycles = 0;
    int   lines_cycle;
    int   waited;

    `include "tb_trap_unit_checks.svh"

    trap_unit #(.SYNC_STAGES(SYNC_STAGES)) UUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= RESET_CYCLES + 4 * rows.size() + 50) begin
            $display("timeout: run did not finish within %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic add_row(input int op, input csr_addr_t addr, input xlen_t a, input xlen_t b,
                           input xlen_t c, input xlen_t exp_val, input priv_e exp_prv,
                           input logic exp_irq, input logic exp_eret);
        row_t r;
        r.op       = op;
        r.addr     = addr;
        r.a        = a;
        r.b        = b;
        r.c        = c;
        r.exp_val  = exp_val;
        r.exp_prv  = exp_prv;
        r.exp_irq  = exp_irq;
        r.exp_eret = exp_eret;
        rows.push_back(r);
    endtask

    task automatic fill_table();
        xlen_t scratch_data;
        scratch_data = lcg_next();
        // reset values.
        add_row(OP_RD, CSR_MSTATUS, '0, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        add_row(OP_RD, CSR_MIE, '0, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        add_row(OP_RD, CSR_MTVEC, '0, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        add_row(OP_RD, CSR_MEPC, '0, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        add_row(OP_RD, CSR_MCAUSE, '0, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        // CSR access and the write masks.
        add_row(OP_WR, CSR_MSCRATCH, scratch_data, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        add_row(OP_RD, CSR_MSCRATCH, '0, '0, '0, scratch_data, PRV_M, 1'b0, 1'b0);
        add_row(OP_WR, CSR_MEPC, 32'h8000_0103, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        add_row(OP_RD, CSR_MEPC, '0, '0, '0, 32'h8000_0103 & ~32'h1, PRV_M, 1'b0, 1'b0);
        add_row(OP_WR, CSR_MTVEC, 32'h0000_1003, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        add_row(OP_RD, CSR_MTVEC, '0, '0, '0, 32'h0000_1003 & ~32'h2, PRV_M, 1'b0, 1'b0);
        add_row(OP_WR, CSR_MIE, 32'hffff_ffff, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        add_row(OP_RD, CSR_MIE, '0, '0, '0, 32'h0000_0888, PRV_M, 1'b0, 1'b0);
        add_row(OP_RD, 12'h7c0, '0, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        // mret into user mode, then a synchronous trap back to machine mode.
        add_row(OP_WR, CSR_MSTATUS, 32'h0000_0080, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        add_row(OP_MRET, '0, '0, '0, '0, 32'h8000_0102, PRV_M, 1'b0, 1'b1);
        add_row(OP_RD, CSR_MSTATUS, '0, '0, '0, 32'h0000_0088, PRV_U, 1'b0, 1'b0);
        add_row(OP_TRAP, '0, 32'h0000_2005, 32'd2, 32'hdead_beef, 32'h0000_1000,
                PRV_U, 1'b0, 1'b0);
        add_row(OP_RD, CSR_MSTATUS, '0, '0, '0, 32'h0000_0080, PRV_M, 1'b0, 1'b0);
        add_row(OP_RD, CSR_MEPC, '0, '0, '0, 32'h0000_2004, PRV_M, 1'b0, 1'b0);
        add_row(OP_RD, CSR_MCAUSE, '0, '0, '0, 32'd2, PRV_M, 1'b0, 1'b0);
        add_row(OP_RD, CSR_MTVAL, '0, '0, '0, 32'hdead_beef, PRV_M, 1'b0, 1'b0);
        // all lines at once; MEIP wins, vectored to base plus 4 * 11.
        add_row(OP_WR, CSR_MSTATUS, 32'h0000_1808, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        add_row(OP_LINES, '0, 32'h7, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        add_row(OP_WAIT, '0, '0, 32'h8000_000b, SYNC_STAGES, 32'h0000_102c, PRV_M, 1'b1, 1'b0);
        add_row(OP_RD, CSR_MCAUSE, '0, '0, '0, 32'h8000_000b, PRV_M, 1'b0, 1'b0);
        // MEIP dropped, so MSIP beats MTIP.
        add_row(OP_LINES, '0, 32'h3, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        add_row(OP_WR, CSR_MSTATUS, 32'h0000_1808, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        add_row(OP_WAIT, '0, '0, 32'h8000_0003, SYNC_STAGES, 32'h0000_100c, PRV_M, 1'b1, 1'b0);
        // user mode with MIE clear still takes MTIP.
        add_row(OP_LINES, '0, 32'h0, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        add_row(OP_WR, CSR_MSTATUS, 32'h0, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        add_row(OP_MRET, '0, '0, '0, '0, 32'h0, PRV_M, 1'b0, 1'b1);
        // MIE takes the cleared MPIE while MPIE itself is set.
        add_row(OP_RD, CSR_MSTATUS, '0, '0, '0, 32'h0000_0080, PRV_U, 1'b0, 1'b0);
        add_row(OP_LINES, '0, 32'h2, '0, '0, '0, PRV_U, 1'b0, 1'b0);
        add_row(OP_WAIT, '0, '0, 32'h8000_0007, SYNC_STAGES, 32'h0000_101c, PRV_U, 1'b1, 1'b0);
        add_row(OP_RD, CSR_MSTATUS, '0, '0, '0, 32'h0, PRV_M, 1'b0, 1'b0);
        add_row(OP_RD, CSR_MIP, '0, '0, '0, 32'h0000_0080, PRV_M, 1'b0, 1'b0);
        // trap beats a pending interrupt, the interrupt beats mret.
        add_row(OP_WR, CSR_MSTATUS, 32'h0000_1808, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        add_row(OP_TRAP, '0, 32'h0000_3000, 32'd5, 32'h55, 32'h0000_1000, PRV_M, 1'b0, 1'b0);
        add_row(OP_RD, CSR_MCAUSE, '0, '0, '0, 32'd5, PRV_M, 1'b0, 1'b0);
        add_row(OP_WR, CSR_MSTATUS, 32'h0000_0008, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        add_row(OP_MRET, '0, '0, '0, '0, 32'h0000_3000, PRV_M, 1'b1, 1'b0);
        add_row(OP_RD, CSR_MCAUSE, '0, '0, '0, 32'h8000_0007, PRV_M, 1'b0, 1'b0);
        add_row(OP_LINES, '0, 32'h0, '0, '0, '0, PRV_M, 1'b0, 1'b0);
        // mret with MPP at machine stays in machine mode and drops MPP to user.
        add_row(OP_MRET, '0, '0, '0, '0, 32'h0, PRV_M, 1'b0, 1'b1);
        add_row(OP_RD, CSR_MSTATUS, '0, '0, '0, 32'h0000_0088, PRV_M, 1'b0, 1'b0);
    endtask

    // interrupt lines hold their value between rows.
    task automatic drive_idle();
        csr_wr     = 1'b0;
        csr_waddr  = '0;
        csr_raddr  = '0;
        csr_wdata  = '0;
        trap_en    = 1'b0;
        trap_epc   = '0;
        trap_cause = '0;
        trap_val   = '0;
        mret       = 1'b0;
    endtask

    task automatic apply_row(input row_t r);
        drive_idle();
        case (r.op)
            OP_WR: begin
                csr_wr    = 1'b1;
                csr_waddr = r.addr;
                csr_wdata = r.a;
            end
            OP_RD: csr_raddr = r.addr;
            OP_TRAP: begin
                trap_en    = 1'b1;
                trap_epc   = r.a;
                trap_cause = r.b;
                trap_val   = r.c;
            end
            OP_MRET: mret = 1'b1;
            OP_LINES: begin
                {ext_meip, ext_mtip, ext_msip} = r.a[2:0];
                lines_cycle = cycles;
            end
            OP_WAIT: begin
                waited = 0;
                while (!irq_trigger && waited < SYNC_STAGES + 2) begin
                    @(posedge clk);
                    #1;
                    waited++;
                end
            end
            default: ;
        endcase
    endtask

    task automatic check_row(input row_t r);
        check_priv("prv", prv, r.exp_prv);
        check_bit("irq_trigger", irq_trigger, r.exp_irq);
        check_bit("eret_en", eret_en, r.exp_eret);
        case (r.op)
            OP_RD: check_xlen("csr_rdata", csr_rdata, r.exp_val);
            OP_TRAP: begin
                check_xlen("trap_vec", trap_vec, r.exp_val);
                check_xlen("cause", cause, r.b);
                check_xlen("tval", tval, r.c);
            end
            OP_MRET: check_xlen("ret_epc", ret_epc, r.exp_val);
            OP_WAIT: begin
                if (!irq_trigger) begin
                    report_error("the interrupt never arrived");
                end
                // edges from raising the lines to irq_trigger.
                check_xlen("irq latency", xlen_t'(cycles - lines_cycle), r.c);
                check_xlen("trap_vec", trap_vec, r.exp_val);
                check_xlen("cause", cause, r.b);
            end
            default: ;
        endcase
    endtask

    initial begin
        clk      = 1'b0;
        rstn     = 1'b0;
        ext_msip = 1'b0;
        ext_mtip = 1'b0;
        ext_meip = 1'b0;
        drive_idle();
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #1;
            apply_row(rows[i]);
            @(negedge clk);
            check_row(rows[i]);
        end
        @(posedge clk);
        $display("error summary: %0d mismatches, %0d other failures",
                 mismatch_count, other_error_count);
        if (mismatch_count == 0 && other_error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== trap_unit.f ====
+incdir+sim
hw/trap_pkg.sv
hw/irq_arbiter.sv
hw/priv_fsm.sv
hw/trap_csr_file.sv
hw/trap_unit.sv
sim/tb_trap_unit.sv
